/* hdl/soc_macros.svh */
// SoC interconnect constants
// Bus widths, memory map and default L2 depth

`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// Bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 64
`define SOC_STRB_W 8
`define APB_W      32

// Region bases
`define L2_BASE   32'h8000_0000
`define UART_BASE 32'hC000_0000
`define CTRL_BASE 32'hD000_0000

// Region lengths in bytes
`define L2_LEN   32'h0000_2000
`define UART_LEN 32'h0000_1000
`define CTRL_LEN 32'h0000_1000

// 1024 words of 64 bits fill the 8 KiB L2 region
`define L2_WORDS 1024

`endif

/* hdl/soc_pkg.sv */
// SoC package
// Bus word types and control register offsets

`include "soc_macros.svh"

package soc_pkg;

  //////////////////////////////////////////////////
  // Bus words
  //////////////////////////////////////////////////

  typedef logic [`SOC_ADDR_W-1:0] addr_t;
  typedef logic [`SOC_DATA_W-1:0] data_t;
  typedef logic [`SOC_STRB_W-1:0] strb_t;

  //////////////////////////////////////////////////
  // Control register map
  //////////////////////////////////////////////////

  // Byte offsets within the control region
  typedef enum logic [7:0] {
    CTRL_EXIT      = 8'h00,
    CTRL_HW_CNT_EN = 8'h08
  } ctrl_reg_e;

endpackage

/* hdl/mem_bus_if.sv */
// Memory-style bus between the address decoder and one target
// Request with req/gnt, response as a single rvalid pulse

`timescale 1ns/1ps

interface mem_bus_if;

  // Request
  logic           req;
  logic           gnt;
  logic           we;
  soc_pkg::addr_t addr;
  soc_pkg::data_t wdata;
  soc_pkg::strb_t be;

  // Response
  logic           rvalid;
  soc_pkg::data_t rdata;
  logic           err;

  modport initiator (
    output req, we, addr, wdata, be,
    input  gnt, rvalid, rdata, err
  );

  modport target (
    input  req, we, addr, wdata, be,
    output gnt, rvalid, rdata, err
  );

endinterface

/* hdl/soc_addr_decoder.sv */
// Address decoder for the host port
// Routes one outstanding request to L2, UART or control registers

`timescale 1ns/1ps

`include "soc_macros.svh"

module soc_addr_decoder (
  input  logic             clk_i,
  input  logic             reset_i,
  // Host port
  input  logic             host_req_i,
  output logic             host_gnt_o,
  input  logic             host_we_i,
  input  soc_pkg::addr_t   host_addr_i,
  input  soc_pkg::data_t   host_wdata_i,
  input  soc_pkg::strb_t   host_be_i,
  output logic             host_rvalid_o,
  output soc_pkg::data_t   host_rdata_o,
  output logic             host_err_o,
  // Targets
  mem_bus_if.initiator     l2_bus,
  mem_bus_if.initiator     uart_bus,
  mem_bus_if.initiator     ctrl_bus
);

  typedef enum logic [1:0] {
    TGT_NONE,
    TGT_L2,
    TGT_UART,
    TGT_CTRL
  } tgt_e;

  logic hit_l2;
  logic hit_uart;
  logic hit_ctrl;
  tgt_e tgt_d;
  tgt_e tgt_q;
  logic busy_q;
  logic accept;
  logic unmapped_rvalid_q;

  //////////////////////////////////////////////////
  // Region match
  //////////////////////////////////////////////////

  assign hit_l2   = (host_addr_i >= `L2_BASE) && (host_addr_i < `L2_BASE + `L2_LEN);
  assign hit_uart = (host_addr_i >= `UART_BASE) && (host_addr_i < `UART_BASE + `UART_LEN);
  assign hit_ctrl = (host_addr_i >= `CTRL_BASE) && (host_addr_i < `CTRL_BASE + `CTRL_LEN);

  always_comb begin
    tgt_d = TGT_NONE;
    if (hit_l2) begin
      tgt_d = TGT_L2;
    end else if (hit_uart) begin
      tgt_d = TGT_UART;
    end else if (hit_ctrl) begin
      tgt_d = TGT_CTRL;
    end
  end

  // Requests are held off while a response is pending
  assign l2_bus.req   = host_req_i && !busy_q && (tgt_d == TGT_L2);
  assign uart_bus.req = host_req_i && !busy_q && (tgt_d == TGT_UART);
  assign ctrl_bus.req = host_req_i && !busy_q && (tgt_d == TGT_CTRL);

  assign l2_bus.we      = host_we_i;
  assign l2_bus.addr    = host_addr_i;
  assign l2_bus.wdata   = host_wdata_i;
  assign l2_bus.be      = host_be_i;
  assign uart_bus.we    = host_we_i;
  assign uart_bus.addr  = host_addr_i;
  assign uart_bus.wdata = host_wdata_i;
  assign uart_bus.be    = host_be_i;
  assign ctrl_bus.we    = host_we_i;
  assign ctrl_bus.addr  = host_addr_i;
  assign ctrl_bus.wdata = host_wdata_i;
  assign ctrl_bus.be    = host_be_i;

  always_comb begin
    host_gnt_o = 1'b0;
    if (!busy_q) begin
      case (tgt_d)
        TGT_L2:   host_gnt_o = l2_bus.gnt;
        TGT_UART: host_gnt_o = uart_bus.gnt;
        TGT_CTRL: host_gnt_o = ctrl_bus.gnt;
        default:  host_gnt_o = host_req_i;
      endcase
    end
  end

  assign accept = host_req_i && host_gnt_o;

  //////////////////////////////////////////////////
  // Outstanding transaction
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q            <= 1'b0;
      tgt_q             <= TGT_NONE;
      unmapped_rvalid_q <= 1'b0;
    end else begin
      // Unmapped accesses answer on their own, one cycle later
      unmapped_rvalid_q <= accept && (tgt_d == TGT_NONE);
      if (accept) begin
        busy_q <= 1'b1;
        tgt_q  <= tgt_d;
      end else if (host_rvalid_o) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Response mux
  always_comb begin
    case (tgt_q)
      TGT_L2: begin
        host_rvalid_o = l2_bus.rvalid;
        host_rdata_o  = l2_bus.rdata;
        host_err_o    = l2_bus.err;
      end
      TGT_UART: begin
        host_rvalid_o = uart_bus.rvalid;
        host_rdata_o  = uart_bus.rdata;
        host_err_o    = uart_bus.err;
      end
      TGT_CTRL: begin
        host_rvalid_o = ctrl_bus.rvalid;
        host_rdata_o  = ctrl_bus.rdata;
        host_err_o    = ctrl_bus.err;
      end
      default: begin
        host_rvalid_o = unmapped_rvalid_q;
        host_rdata_o  = '0;
        host_err_o    = unmapped_rvalid_q;
      end
    endcase
  end

endmodule

/* hdl/l2_mem.sv */
// L2 SRAM
// Single port, byte-enabled writes, one-cycle read latency

`timescale 1ns/1ps

`include "soc_macros.svh"

module l2_mem #(
  parameter int unsigned NumWords = `L2_WORDS
) (
  input  logic     clk_i,
  input  logic     reset_i,
  mem_bus_if.target bus
);

  localparam int unsigned IdxW = $clog2(NumWords);
  localparam int unsigned OffW = $clog2(`SOC_STRB_W);

  soc_pkg::data_t mem [NumWords];
  soc_pkg::addr_t region_off;
  logic [IdxW-1:0] idx;
  logic            rvalid_q;
  soc_pkg::data_t  rdata_q;

  // Always ready
  assign bus.gnt = bus.req;

  // Word index inside the region
  assign region_off = bus.addr - `L2_BASE;
  assign idx        = region_off[OffW +: IdxW];

  always_ff @(posedge clk_i) begin
    if (bus.req && bus.we) begin
      for (int b = 0; b < `SOC_STRB_W; b++) begin
        if (bus.be[b]) begin
          mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
    if (bus.req && !bus.we) begin
      rdata_q <= mem[idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

endmodule

/* hdl/apb_bridge.sv */
// Memory bus to APB bridge toward the UART
// One transfer at a time through setup and access phases

`timescale 1ns/1ps

`include "soc_macros.svh"

module apb_bridge (
  input  logic              clk_i,
  input  logic              reset_i,
  mem_bus_if.target         bus,
  // UART APB
  output logic              uart_psel_o,
  output logic              uart_penable_o,
  output logic              uart_pwrite_o,
  output logic [`APB_W-1:0] uart_paddr_o,
  output logic [`APB_W-1:0] uart_pwdata_o,
  input  logic [`APB_W-1:0] uart_prdata_i,
  input  logic              uart_pready_i,
  input  logic              uart_pslverr_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS,
    ST_RESPOND
  } state_e;

  state_e            state_q;
  logic              pwrite_q;
  logic [`APB_W-1:0] paddr_q;
  logic [`APB_W-1:0] pwdata_q;
  logic [`APB_W-1:0] prdata_q;
  logic              pslverr_q;

  assign bus.gnt = (state_q == ST_IDLE);

  //////////////////////////////////////////////////
  // Phase FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (bus.req) begin
            state_q <= ST_SETUP;
          end
        end
        ST_SETUP: state_q <= ST_ACCESS;
        ST_ACCESS: begin
          // Wait states stretch the access phase
          if (uart_pready_i) begin
            state_q <= ST_RESPOND;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Request and response capture
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && bus.req) begin
      pwrite_q <= bus.we;
      paddr_q  <= `APB_W'(bus.addr - `UART_BASE);
      pwdata_q <= bus.wdata[`APB_W-1:0];
    end
    if (state_q == ST_ACCESS && uart_pready_i) begin
      prdata_q  <= pwrite_q ? '0 : uart_prdata_i;
      pslverr_q <= uart_pslverr_i;
    end
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  assign uart_psel_o    = (state_q == ST_SETUP) || (state_q == ST_ACCESS);
  assign uart_penable_o = (state_q == ST_ACCESS);
  assign uart_pwrite_o  = pwrite_q;
  assign uart_paddr_o   = paddr_q;
  assign uart_pwdata_o  = pwdata_q;

  assign bus.rvalid = (state_q == ST_RESPOND);
  assign bus.rdata  = {{(`SOC_DATA_W-`APB_W){1'b0}}, prdata_q};
  assign bus.err    = pslverr_q;

endmodule

/* hdl/ctrl_regs.sv */
// Control registers
// Exit code and hardware counter enable, bus readable and writable

`timescale 1ns/1ps

`include "soc_macros.svh"

module ctrl_regs (
  input  logic           clk_i,
  input  logic           reset_i,
  mem_bus_if.target      bus,
  output soc_pkg::data_t exit_o,
  output soc_pkg::data_t hw_cnt_en_o
);

  soc_pkg::addr_t region_off;
  logic           hit_exit;
  logic           hit_cnt_en;
  soc_pkg::data_t exit_q;
  soc_pkg::data_t cnt_en_q;
  logic           rvalid_q;
  soc_pkg::data_t rdata_q;
  logic           err_q;

  assign bus.gnt = bus.req;

  // Offset decode
  assign region_off = bus.addr - `CTRL_BASE;
  assign hit_exit   = (region_off == soc_pkg::addr_t'(soc_pkg::CTRL_EXIT));
  assign hit_cnt_en = (region_off == soc_pkg::addr_t'(soc_pkg::CTRL_HW_CNT_EN));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exit_q   <= '0;
      cnt_en_q <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
      if (bus.req && bus.we) begin
        for (int b = 0; b < `SOC_STRB_W; b++) begin
          if (bus.be[b] && hit_exit) begin
            exit_q[8*b +: 8] <= bus.wdata[8*b +: 8];
          end
          if (bus.be[b] && hit_cnt_en) begin
            cnt_en_q[8*b +: 8] <= bus.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  // Read data and error, one cycle after the request
  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      err_q <= !(hit_exit || hit_cnt_en);
      if (!bus.we && hit_exit) begin
        rdata_q <= exit_q;
      end else if (!bus.we && hit_cnt_en) begin
        rdata_q <= cnt_en_q;
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign bus.rvalid  = rvalid_q;
  assign bus.rdata   = rdata_q;
  assign bus.err     = err_q;
  assign exit_o      = exit_q;
  assign hw_cnt_en_o = cnt_en_q;

endmodule

/* hdl/soc_top.sv */
// SoC interconnect top level
// Host memory port, L2 SRAM, UART APB bridge and control registers

`timescale 1ns/1ps

`include "soc_macros.svh"

module soc_top (
  input  logic              clk_i,
  input  logic              reset_i,
  // Host memory port
  input  logic              host_req_i,
  output logic              host_gnt_o,
  input  logic              host_we_i,
  input  soc_pkg::addr_t    host_addr_i,
  input  soc_pkg::data_t    host_wdata_i,
  input  soc_pkg::strb_t    host_be_i,
  output logic              host_rvalid_o,
  output soc_pkg::data_t    host_rdata_o,
  output logic              host_err_o,
  // Control outputs
  output soc_pkg::data_t    exit_o,
  output soc_pkg::data_t    hw_cnt_en_o,
  // UART APB
  output logic              uart_psel_o,
  output logic              uart_penable_o,
  output logic              uart_pwrite_o,
  output logic [`APB_W-1:0] uart_paddr_o,
  output logic [`APB_W-1:0] uart_pwdata_o,
  input  logic [`APB_W-1:0] uart_prdata_i,
  input  logic              uart_pready_i,
  input  logic              uart_pslverr_i
);

  mem_bus_if l2_bus ();
  mem_bus_if uart_bus ();
  mem_bus_if ctrl_bus ();

  //////////////////////////////////////////////////
  // Decoder
  //////////////////////////////////////////////////

  soc_addr_decoder u_decoder (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .host_req_i   (host_req_i),
    .host_gnt_o   (host_gnt_o),
    .host_we_i    (host_we_i),
    .host_addr_i  (host_addr_i),
    .host_wdata_i (host_wdata_i),
    .host_be_i    (host_be_i),
    .host_rvalid_o(host_rvalid_o),
    .host_rdata_o (host_rdata_o),
    .host_err_o   (host_err_o),
    .l2_bus       (l2_bus.initiator),
    .uart_bus     (uart_bus.initiator),
    .ctrl_bus     (ctrl_bus.initiator)
  );

  //////////////////////////////////////////////////
  // Targets
  //////////////////////////////////////////////////

  l2_mem #(
    .NumWords(`L2_WORDS)
  ) u_l2_mem (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .bus    (l2_bus.target)
  );

  apb_bridge u_apb_bridge (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .bus           (uart_bus.target),
    .uart_psel_o   (uart_psel_o),
    .uart_penable_o(uart_penable_o),
    .uart_pwrite_o (uart_pwrite_o),
    .uart_paddr_o  (uart_paddr_o),
    .uart_pwdata_o (uart_pwdata_o),
    .uart_prdata_i (uart_prdata_i),
    .uart_pready_i (uart_pready_i),
    .uart_pslverr_i(uart_pslverr_i)
  );

  ctrl_regs u_ctrl_regs (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .bus        (ctrl_bus.target),
    .exit_o     (exit_o),
    .hw_cnt_en_o(hw_cnt_en_o)
  );

endmodule

/* bench/tb_checker.sv */
// Response checker for the SoC interconnect testbench
// Compares host responses, control outputs and APB writes with expected values

`timescale 1ns/1ps

`include "soc_macros.svh"

module tb_checker (
  input  logic           clk_i,
  input  logic           reset_i,
  // Expected values of the transaction in flight
  input  logic           exp_stb_i,
  input  logic           exp_we_i,
  input  soc_pkg::addr_t exp_addr_i,
  input  soc_pkg::data_t exp_wdata_i,
  input  soc_pkg::data_t exp_rdata_i,
  input  logic           exp_err_i,
  input  soc_pkg::data_t exp_exit_i,
  input  soc_pkg::data_t exp_cnt_en_i,
  // Observed DUT signals
  input  logic           host_rvalid_i,
  input  soc_pkg::data_t host_rdata_i,
  input  logic           host_err_i,
  input  soc_pkg::data_t exit_i,
  input  soc_pkg::data_t hw_cnt_en_i,
  input  int unsigned    apb_wr_cnt_i,
  input  logic [31:0]    apb_wr_addr_i,
  input  logic [31:0]    apb_wr_data_i,
  output int unsigned    err_cnt_o,
  output int unsigned    chk_cnt_o
);

  int unsigned    err_cnt = 0;
  int unsigned    chk_cnt = 0;
  logic           reset_checked = 1'b0;
  logic           pending = 1'b0;
  logic           we_q;
  soc_pkg::addr_t addr_q;
  soc_pkg::data_t wdata_q;
  soc_pkg::data_t rdata_q;
  logic           err_q;
  soc_pkg::data_t exit_q;
  soc_pkg::data_t cnt_en_q;
  int unsigned    wr_base;

  assign err_cnt_o = err_cnt;
  assign chk_cnt_o = chk_cnt;

  task automatic check_word(input string name, input soc_pkg::data_t exp,
                            input soc_pkg::data_t got);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL %0t %s exp=%0h got=%0h", $time, name, exp, got);
    end
  endtask

  task automatic report_error(input string msg);
    err_cnt++;
    $display("ERROR %0t %s", $time, msg);
  endtask

  function automatic logic in_uart(input soc_pkg::addr_t addr);
    return (addr >= `UART_BASE) && (addr < `UART_BASE + `UART_LEN);
  endfunction

  //////////////////////////////////////////////////
  // Response compare
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (reset_i) begin
      pending = 1'b0;
    end else begin
      if (!reset_checked) begin
        check_word("exit_o", '0, exit_i);
        check_word("hw_cnt_en_o", '0, hw_cnt_en_i);
        reset_checked = 1'b1;
      end
      // A new expectation can land in the same cycle as a fast response
      if (exp_stb_i) begin
        pending  = 1'b1;
        we_q     = exp_we_i;
        addr_q   = exp_addr_i;
        wdata_q  = exp_wdata_i;
        rdata_q  = exp_rdata_i;
        err_q    = exp_err_i;
        exit_q   = exp_exit_i;
        cnt_en_q = exp_cnt_en_i;
        wr_base  = apb_wr_cnt_i;
      end
      if (host_rvalid_i) begin
        if (!pending) begin
          report_error("rvalid appeared without an outstanding request");
        end else begin
          check_word("host_err_o", soc_pkg::data_t'(err_q), soc_pkg::data_t'(host_err_i));
          if (!we_q) begin
            check_word("host_rdata_o", rdata_q, host_rdata_i);
          end
          check_word("exit_o", exit_q, exit_i);
          check_word("hw_cnt_en_o", cnt_en_q, hw_cnt_en_i);
          if (we_q && in_uart(addr_q)) begin
            if (apb_wr_cnt_i != wr_base + 1) begin
              report_error("UART write did not show up exactly once on the APB bus");
            end
            check_word("uart_paddr_o", soc_pkg::data_t'(addr_q - `UART_BASE),
                       soc_pkg::data_t'(apb_wr_addr_i));
            check_word("uart_pwdata_o", soc_pkg::data_t'(wdata_q[31:0]),
                       soc_pkg::data_t'(apb_wr_data_i));
          end
          pending = 1'b0;
        end
      end
    end
  end

endmodule

/* bench/tb_top.sv */
// Testbench top for the SoC interconnect
// Clock, reset, APB slave model and a table-driven host stimulus loop

`timescale 1ns/1ps

`include "soc_macros.svh"

module tb_top;

  localparam int unsigned ResetCycles  = 10;
  localparam logic [31:0] RdataMask    = 32'hA5A5_0000;
  localparam logic [31:0] ErrOffset    = 32'h0000_0FFC;
  localparam logic [31:0] CtrlExitAddr = `CTRL_BASE + 32'(soc_pkg::CTRL_EXIT);
  localparam logic [31:0] CtrlCntAddr  = `CTRL_BASE + 32'(soc_pkg::CTRL_HW_CNT_EN);
  localparam logic [31:0] CtrlBadAddr  = `CTRL_BASE + 32'h0000_0010;

  typedef struct packed {
    logic           we;
    soc_pkg::addr_t addr;
    soc_pkg::data_t wdata;
    soc_pkg::strb_t be;
    soc_pkg::data_t rdata;
    logic           err;
    soc_pkg::data_t exit_v;
    soc_pkg::data_t cnt_en;
  } entry_t;

  logic clk = 1'b0;
  logic reset = 1'b1;

  // Host port
  logic           host_req = 1'b0;
  logic           host_we = 1'b0;
  soc_pkg::addr_t host_addr = '0;
  soc_pkg::data_t host_wdata = '0;
  soc_pkg::strb_t host_be = '0;
  logic           host_gnt_o;
  logic           host_rvalid_o;
  soc_pkg::data_t host_rdata_o;
  logic           host_err_o;
  soc_pkg::data_t exit_o;
  soc_pkg::data_t hw_cnt_en_o;

  // UART APB
  logic        apb_psel;
  logic        apb_penable;
  logic        apb_pwrite;
  logic [31:0] apb_paddr;
  logic [31:0] apb_pwdata;
  logic [31:0] apb_prdata = '0;
  logic        apb_pready = 1'b0;
  logic        apb_pslverr = 1'b0;
  logic [1:0]  wait_cnt = '0;
  logic [31:0] lcg_state = 32'h1bb1;
  int unsigned apb_wr_cnt = 0;
  logic [31:0] apb_wr_addr = '0;
  logic [31:0] apb_wr_data = '0;

  // Expectation handed to the checker
  logic   exp_stb = 1'b0;
  entry_t exp_q = '0;

  entry_t      table_q [$];
  int unsigned cycle_cnt = 0;
  int unsigned cycle_limit = 0;
  int unsigned err_cnt;
  int unsigned chk_cnt;

  always #2 clk = ~clk;

  soc_top u_dut (
    .clk_i         (clk),
    .reset_i       (reset),
    .host_req_i    (host_req),
    .host_gnt_o    (host_gnt_o),
    .host_we_i     (host_we),
    .host_addr_i   (host_addr),
    .host_wdata_i  (host_wdata),
    .host_be_i     (host_be),
    .host_rvalid_o (host_rvalid_o),
    .host_rdata_o  (host_rdata_o),
    .host_err_o    (host_err_o),
    .exit_o        (exit_o),
    .hw_cnt_en_o   (hw_cnt_en_o),
    .uart_psel_o   (apb_psel),
    .uart_penable_o(apb_penable),
    .uart_pwrite_o (apb_pwrite),
    .uart_paddr_o  (apb_paddr),
    .uart_pwdata_o (apb_pwdata),
    .uart_prdata_i (apb_prdata),
    .uart_pready_i (apb_pready),
    .uart_pslverr_i(apb_pslverr)
  );

  tb_checker u_chk (
    .clk_i        (clk),
    .reset_i      (reset),
    .exp_stb_i    (exp_stb),
    .exp_we_i     (exp_q.we),
    .exp_addr_i   (exp_q.addr),
    .exp_wdata_i  (exp_q.wdata),
    .exp_rdata_i  (exp_q.rdata),
    .exp_err_i    (exp_q.err),
    .exp_exit_i   (exp_q.exit_v),
    .exp_cnt_en_i (exp_q.cnt_en),
    .host_rvalid_i(host_rvalid_o),
    .host_rdata_i (host_rdata_o),
    .host_err_i   (host_err_o),
    .exit_i       (exit_o),
    .hw_cnt_en_i  (hw_cnt_en_o),
    .apb_wr_cnt_i (apb_wr_cnt),
    .apb_wr_addr_i(apb_wr_addr),
    .apb_wr_data_i(apb_wr_data),
    .err_cnt_o    (err_cnt),
    .chk_cnt_o    (chk_cnt)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  //////////////////////////////////////////////////
  // APB slave model
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    logic [31:0] rnd;
    if (reset) begin
      apb_pready <= 1'b0;
      wait_cnt   <= '0;
    end else if (apb_psel && !apb_penable) begin
      // Setup phase draws 0 to 3 wait states
      rnd         = lcg_next();
      wait_cnt    <= rnd[17:16];
      apb_pready  <= (rnd[17:16] == 2'd0);
      apb_prdata  <= apb_paddr ^ RdataMask;
      apb_pslverr <= (apb_paddr == ErrOffset);
    end else if (apb_psel && apb_penable && !apb_pready) begin
      wait_cnt   <= wait_cnt - 2'd1;
      apb_pready <= (wait_cnt == 2'd1);
    end else begin
      if (apb_psel && apb_penable && apb_pwrite) begin
        apb_wr_cnt  <= apb_wr_cnt + 1;
        apb_wr_addr <= apb_paddr;
        apb_wr_data <= apb_pwdata;
      end
      apb_pready <= 1'b0;
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: no response from the DUT after %0d cycles", cycle_cnt);
      $display("Checks %0d, errors %0d", chk_cnt, err_cnt);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  task automatic add_entry(input logic we, input soc_pkg::addr_t addr,
                           input soc_pkg::data_t wdata, input soc_pkg::strb_t be,
                           input soc_pkg::data_t rdata, input logic err,
                           input soc_pkg::data_t exit_v, input soc_pkg::data_t cnt_en);
    table_q.push_back({we, addr, wdata, be, rdata, err, exit_v, cnt_en});
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    entry_t cur;
    // Registers are zero straight after reset
    add_entry(1'b0, CtrlExitAddr, 64'h0, 8'hFF, 64'h0, 1'b0, 64'h0, 64'h0);
    add_entry(1'b0, CtrlCntAddr, 64'h0, 8'hFF, 64'h0, 1'b0, 64'h0, 64'h0);
    // L2 byte enables
    add_entry(1'b1, 32'h8000_0000, 64'h1122_3344_5566_7788, 8'hFF, 64'h0, 1'b0, 64'h0, 64'h0);
    add_entry(1'b1, 32'h8000_0000, 64'hAAAA_BBBB_CCCC_DDDD, 8'h0F, 64'h0, 1'b0, 64'h0, 64'h0);
    add_entry(1'b0, 32'h8000_0000, 64'h0, 8'hFF, 64'h1122_3344_CCCC_DDDD, 1'b0, 64'h0, 64'h0);
    add_entry(1'b1, 32'h8000_1FF8, 64'hDEAD_BEEF_0BAD_F00D, 8'hFF, 64'h0, 1'b0, 64'h0, 64'h0);
    add_entry(1'b1, 32'h8000_1FF8, 64'h0123_4567_89AB_CDEF, 8'h81, 64'h0, 1'b0, 64'h0, 64'h0);
    add_entry(1'b0, 32'h8000_1FF8, 64'h0, 8'hFF, 64'h01AD_BEEF_0BAD_F0EF, 1'b0, 64'h0, 64'h0);
    // Control registers
    add_entry(1'b1, CtrlExitAddr, 64'h1, 8'hFF, 64'h0, 1'b0, 64'h1, 64'h0);
    add_entry(1'b1, CtrlCntAddr, 64'hFFFF_0000_1234_5678, 8'h0F, 64'h0, 1'b0,
              64'h1, 64'h1234_5678);
    add_entry(1'b0, CtrlExitAddr, 64'h0, 8'hFF, 64'h1, 1'b0, 64'h1, 64'h1234_5678);
    add_entry(1'b0, CtrlCntAddr, 64'h0, 8'hFF, 64'h1234_5678, 1'b0, 64'h1, 64'h1234_5678);
    add_entry(1'b1, CtrlBadAddr, '1, 8'hFF, 64'h0, 1'b1, 64'h1, 64'h1234_5678);
    add_entry(1'b0, CtrlBadAddr, 64'h0, 8'hFF, 64'h0, 1'b1, 64'h1, 64'h1234_5678);
    // UART through the APB bridge
    add_entry(1'b0, 32'hC000_0004, 64'h0, 8'hFF, 64'hA5A5_0004, 1'b0, 64'h1, 64'h1234_5678);
    add_entry(1'b0, 32'hC000_0100, 64'h0, 8'hFF, 64'hA5A5_0100, 1'b0, 64'h1, 64'h1234_5678);
    add_entry(1'b1, 32'hC000_0008, 64'hFFFF_FFFF_CAFE_0042, 8'hFF, 64'h0, 1'b0,
              64'h1, 64'h1234_5678);
    add_entry(1'b0, 32'hC000_0FFC, 64'h0, 8'hFF, 64'hA5A5_0FFC, 1'b1, 64'h1, 64'h1234_5678);
    add_entry(1'b1, 32'hC000_0FFC, 64'h5A5A, 8'hFF, 64'h0, 1'b1, 64'h1, 64'h1234_5678);
    // Unmapped
    add_entry(1'b0, 32'h0000_1000, 64'h0, 8'hFF, 64'h0, 1'b1, 64'h1, 64'h1234_5678);
    add_entry(1'b1, 32'hFFFF_0000, 64'h77, 8'hFF, 64'h0, 1'b1, 64'h1, 64'h1234_5678);
    add_entry(1'b0, 32'hC000_03F0, 64'h0, 8'hFF, 64'hA5A5_03F0, 1'b0, 64'h1, 64'h1234_5678);
    add_entry(1'b0, 32'h8000_0000, 64'h0, 8'hFF, 64'h1122_3344_CCCC_DDDD, 1'b0,
              64'h1, 64'h1234_5678);
    cycle_limit = table_q.size() * 12 + ResetCycles;

    repeat (ResetCycles) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    for (int i = 0; i < table_q.size(); i++) begin
      cur = table_q[i];
      host_req   <= 1'b1;
      host_we    <= cur.we;
      host_addr  <= cur.addr;
      host_wdata <= cur.wdata;
      host_be    <= cur.be;
      @(posedge clk);
      while (!host_gnt_o) @(posedge clk);
      host_req <= 1'b0;
      exp_stb  <= 1'b1;
      exp_q    <= cur;
      @(posedge clk);
      exp_stb <= 1'b0;
      while (!host_rvalid_o) @(posedge clk);
    end

    repeat (2) @(posedge clk);
    $display("Checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+hdl
hdl/soc_pkg.sv
hdl/mem_bus_if.sv
hdl/soc_addr_decoder.sv
hdl/l2_mem.sv
hdl/apb_bridge.sv
hdl/ctrl_regs.sv
hdl/soc_top.sv
bench/tb_checker.sv
bench/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the SoC interconnect testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps --top-module tb_top -f vlog.f -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "Simulation failed"
  exit 1
fi

echo "Simulation finished without failures"
